//--- hdl/tsc_pkg.sv
`default_nettype none

package tsc_pkg;

    // Data and instruction width.
    localparam int word_size = 16;

    // Index into the four general registers.
    typedef logic [1:0] reg_addr_t;

    // Major opcodes in instr[15:12].
    typedef enum logic [3:0] {
        op_adi   = 4'd4,  // Add sign-extended immediate.
        op_ori   = 4'd5,  // Or with zero-extended immediate.
        op_lhi   = 4'd6,  // Immediate into the upper byte.
        op_lwd   = 4'd7,
        op_swd   = 4'd8,
        op_rtype = 4'd15  // Function field selects the operation.
    } opcode_e;

    // R-type function codes in instr[5:0].
    typedef enum logic [5:0] {
        func_add = 6'd0,
        func_sub = 6'd1,
        func_and = 6'd2,
        func_orr = 6'd3,
        func_not = 6'd4,
        func_tcp = 6'd5,  // Two's complement.
        func_shl = 6'd6,
        func_shr = 6'd7,
        func_wwd = 6'd28, // Write word to the output port.
        func_hlt = 6'd29
    } func_e;

    // Operations carried out by the execute stage ALU.
    // The unary ones (not, tcp and the shifts) work on operand A only.
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_not = 3'd4,
        alu_tcp = 3'd5,
        alu_shl = 3'd6,
        alu_shr = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire tsc_pkg::reg_addr_t          rs_addr,
    input  wire tsc_pkg::reg_addr_t          rt_addr,
    input  wire                              wb_write,
    input  wire tsc_pkg::reg_addr_t          wb_addr,
    input  wire [tsc_pkg::word_size-1:0]     wb_data,
    output logic [tsc_pkg::word_size-1:0]    rs_data,
    output logic [tsc_pkg::word_size-1:0]    rt_data
);

    logic [tsc_pkg::word_size-1:0] regs [4];

    // Reset is active high in this design.
    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // A write in the same cycle is passed straight to the reader.
    always_comb begin
        if (wb_write && (wb_addr == rs_addr)) begin
            rs_data = wb_data;
        end else begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb begin
        if (wb_write && (wb_addr == rt_addr)) begin
            rt_data = wb_data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/control_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module control_decoder (
    input  wire [tsc_pkg::word_size-1:0]     instr,
    output tsc_pkg::opcode_e                 opcode,
    output tsc_pkg::reg_addr_t               rs,
    output tsc_pkg::reg_addr_t               rt,
    output tsc_pkg::reg_addr_t               rd,
    output logic [tsc_pkg::word_size-1:0]    imm,
    output tsc_pkg::alu_op_e                 alu_op,
    output logic                             alu_src_imm,
    output logic                             use_zero_a,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             reg_write,
    output logic                             mem_to_reg,
    output logic                             is_wwd,
    output logic                             is_halt
);

    tsc_pkg::func_e func;
    logic [7:0]     imm8;

    assign opcode = tsc_pkg::opcode_e'(instr[15:12]);
    assign func   = tsc_pkg::func_e'(instr[5:0]);
    assign rs     = instr[11:10];
    assign rt     = instr[9:8];
    assign rd     = instr[7:6];
    assign imm8   = instr[7:0];

    always_comb begin
        // Defaults form a no-operation.
        imm         = {{8{imm8[7]}}, imm8};
        alu_op      = tsc_pkg::alu_add;
        alu_src_imm = 1'b0;
        use_zero_a  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        mem_to_reg  = 1'b0;
        is_wwd      = 1'b0;
        is_halt     = 1'b0;
        case (opcode)
            tsc_pkg::op_adi: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            tsc_pkg::op_ori: begin
                imm         = {8'h00, imm8};
                alu_op      = tsc_pkg::alu_or;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            tsc_pkg::op_lhi: begin
                // Zero or'ed with the shifted immediate gives the loaded value.
                imm         = {imm8, 8'h00};
                alu_op      = tsc_pkg::alu_or;
                alu_src_imm = 1'b1;
                use_zero_a  = 1'b1;
                reg_write   = 1'b1;
            end
            tsc_pkg::op_lwd: begin
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
                mem_to_reg  = 1'b1;
            end
            tsc_pkg::op_swd: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            tsc_pkg::op_rtype: begin
                reg_write = 1'b1;
                case (func)
                    tsc_pkg::func_add: alu_op = tsc_pkg::alu_add;
                    tsc_pkg::func_sub: alu_op = tsc_pkg::alu_sub;
                    tsc_pkg::func_and: alu_op = tsc_pkg::alu_and;
                    tsc_pkg::func_orr: alu_op = tsc_pkg::alu_or;
                    tsc_pkg::func_not: alu_op = tsc_pkg::alu_not;
                    tsc_pkg::func_tcp: alu_op = tsc_pkg::alu_tcp;
                    tsc_pkg::func_shl: alu_op = tsc_pkg::alu_shl;
                    tsc_pkg::func_shr: alu_op = tsc_pkg::alu_shr;
                    tsc_pkg::func_wwd: begin
                        reg_write = 1'b0;
                        is_wwd    = 1'b1;
                    end
                    tsc_pkg::func_hlt: begin
                        reg_write = 1'b0;
                        is_halt   = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire                              stall,
    input  wire                              flush,
    input  wire                              instr_valid,
    input  wire tsc_pkg::opcode_e            opcode_in,
    input  wire tsc_pkg::reg_addr_t          rt_in,
    input  wire tsc_pkg::reg_addr_t          rd_in,
    input  wire [tsc_pkg::word_size-1:0]     imm_in,
    input  wire tsc_pkg::alu_op_e            alu_op_in,
    input  wire                              alu_src_imm_in,
    input  wire                              use_zero_a_in,
    input  wire                              mem_read_in,
    input  wire                              mem_write_in,
    input  wire                              reg_write_in,
    input  wire                              mem_to_reg_in,
    input  wire                              is_wwd_in,
    input  wire                              is_halt_in,
    input  wire [tsc_pkg::word_size-1:0]     rs_data_in,
    input  wire [tsc_pkg::word_size-1:0]     rt_data_in,
    output logic                             valid_out,
    output tsc_pkg::opcode_e                 opcode_out,
    output tsc_pkg::reg_addr_t               rt_out,
    output tsc_pkg::reg_addr_t               rd_out,
    output logic [tsc_pkg::word_size-1:0]    imm_out,
    output tsc_pkg::alu_op_e                 alu_op_out,
    output logic                             alu_src_imm_out,
    output logic                             use_zero_a_out,
    output logic                             mem_read_out,
    output logic                             mem_write_out,
    output logic                             reg_write_out,
    output logic                             mem_to_reg_out,
    output logic                             is_wwd_out,
    output logic                             is_halt_out,
    output logic [tsc_pkg::word_size-1:0]    rs_data_out,
    output logic [tsc_pkg::word_size-1:0]    rt_data_out
);

    // Control bits. Flush wins over stall and leaves a bubble.
    always_ff @(posedge clk) begin
        if (reset_n || flush) begin
            valid_out      <= 1'b0;
            mem_read_out   <= 1'b0;
            mem_write_out  <= 1'b0;
            reg_write_out  <= 1'b0;
            mem_to_reg_out <= 1'b0;
            is_wwd_out     <= 1'b0;
            is_halt_out    <= 1'b0;
        end else if (!stall) begin
            valid_out      <= instr_valid;
            mem_read_out   <= mem_read_in;
            mem_write_out  <= mem_write_in;
            reg_write_out  <= reg_write_in;
            mem_to_reg_out <= mem_to_reg_in;
            is_wwd_out     <= is_wwd_in;
            is_halt_out    <= is_halt_in;
        end
    end

    // Operands and datapath selects; only meaningful while valid_out is set.
    always_ff @(posedge clk) begin
        if (!stall) begin
            opcode_out      <= opcode_in;
            rt_out          <= rt_in;
            rd_out          <= rd_in;
            imm_out         <= imm_in;
            alu_op_out      <= alu_op_in;
            alu_src_imm_out <= alu_src_imm_in;
            use_zero_a_out  <= use_zero_a_in;
            rs_data_out     <= rs_data_in;
            rt_data_out     <= rt_data_in;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
    input  wire                              valid,
    input  wire tsc_pkg::alu_op_e            alu_op,
    input  wire                              alu_src_imm,
    input  wire                              use_zero_a,
    input  wire tsc_pkg::opcode_e            opcode,
    input  wire tsc_pkg::reg_addr_t          rt,
    input  wire tsc_pkg::reg_addr_t          rd,
    input  wire [tsc_pkg::word_size-1:0]     rs_data,
    input  wire [tsc_pkg::word_size-1:0]     rt_data,
    input  wire [tsc_pkg::word_size-1:0]     imm,
    input  wire                              mem_read_in,
    input  wire                              mem_write_in,
    input  wire                              reg_write_in,
    input  wire                              mem_to_reg_in,
    input  wire                              is_wwd,
    input  wire                              is_halt,
    output logic                             ex_valid,
    output logic [tsc_pkg::word_size-1:0]    alu_result,
    output logic [tsc_pkg::word_size-1:0]    store_data,
    output tsc_pkg::reg_addr_t               dest_reg,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             reg_write,
    output logic                             mem_to_reg,
    output logic                             wwd_valid,
    output logic [tsc_pkg::word_size-1:0]    wwd_value,
    output logic                             halted
);

    logic [tsc_pkg::word_size-1:0] op_a;
    logic [tsc_pkg::word_size-1:0] op_b;

    assign op_a = use_zero_a ? '0 : rs_data;
    assign op_b = alu_src_imm ? imm : rt_data;

    always_comb begin
        case (alu_op)
            tsc_pkg::alu_add: alu_result = op_a + op_b;
            tsc_pkg::alu_sub: alu_result = op_a - op_b;
            tsc_pkg::alu_and: alu_result = op_a & op_b;
            tsc_pkg::alu_or:  alu_result = op_a | op_b;
            tsc_pkg::alu_not: alu_result = ~op_a;
            tsc_pkg::alu_tcp: alu_result = ~op_a + 16'd1;
            tsc_pkg::alu_shl: alu_result = op_a << 1;
            tsc_pkg::alu_shr: alu_result = op_a >> 1; // Logical shift.
            default:          alu_result = '0;
        endcase
    end

    // R-type writes rd, every immediate form writes rt.
    assign dest_reg   = (opcode == tsc_pkg::op_rtype) ? rd : rt;
    assign store_data = rt_data;
    assign wwd_value  = rs_data;

    // A bubble must not write anything.
    assign ex_valid   = valid;
    assign mem_read   = valid & mem_read_in;
    assign mem_write  = valid & mem_write_in;
    assign reg_write  = valid & reg_write_in;
    assign mem_to_reg = valid & mem_to_reg_in;
    assign wwd_valid  = valid & is_wwd;
    assign halted     = valid & is_halt;

endmodule

`default_nettype wire

//--- hdl/decode_execute_top.sv
`timescale 1ns/10ps
`default_nettype none

module decode_execute_top (
    input  wire                              clk,
    input  wire                              reset_n,
    input  wire [tsc_pkg::word_size-1:0]     instr,
    input  wire                              instr_valid,
    input  wire                              stall,
    input  wire                              flush,
    input  wire                              wb_write,
    input  wire tsc_pkg::reg_addr_t          wb_addr,
    input  wire [tsc_pkg::word_size-1:0]     wb_data,
    output logic                             ex_valid,
    output logic [tsc_pkg::word_size-1:0]    alu_result,
    output logic [tsc_pkg::word_size-1:0]    store_data,
    output tsc_pkg::reg_addr_t               dest_reg,
    output logic                             mem_read,
    output logic                             mem_write,
    output logic                             reg_write,
    output logic                             mem_to_reg,
    output logic                             wwd_valid,
    output logic [tsc_pkg::word_size-1:0]    wwd_value,
    output logic                             halted
);

    // Decode stage outputs.
    tsc_pkg::opcode_e              dec_opcode;
    tsc_pkg::reg_addr_t            dec_rs;
    tsc_pkg::reg_addr_t            dec_rt;
    tsc_pkg::reg_addr_t            dec_rd;
    logic [tsc_pkg::word_size-1:0] dec_imm;
    tsc_pkg::alu_op_e              dec_alu_op;
    logic                          dec_alu_src_imm;
    logic                          dec_use_zero_a;
    logic                          dec_mem_read;
    logic                          dec_mem_write;
    logic                          dec_reg_write;
    logic                          dec_mem_to_reg;
    logic                          dec_is_wwd;
    logic                          dec_is_halt;
    logic [tsc_pkg::word_size-1:0] dec_rs_data;
    logic [tsc_pkg::word_size-1:0] dec_rt_data;

    // ID/EX register outputs.
    logic                          pipe_valid;
    tsc_pkg::opcode_e              pipe_opcode;
    tsc_pkg::reg_addr_t            pipe_rt;
    tsc_pkg::reg_addr_t            pipe_rd;
    logic [tsc_pkg::word_size-1:0] pipe_imm;
    tsc_pkg::alu_op_e              pipe_alu_op;
    logic                          pipe_alu_src_imm;
    logic                          pipe_use_zero_a;
    logic                          pipe_mem_read;
    logic                          pipe_mem_write;
    logic                          pipe_reg_write;
    logic                          pipe_mem_to_reg;
    logic                          pipe_is_wwd;
    logic                          pipe_is_halt;
    logic [tsc_pkg::word_size-1:0] pipe_rs_data;
    logic [tsc_pkg::word_size-1:0] pipe_rt_data;

    control_decoder i_control_decoder (
        .instr(instr), .opcode(dec_opcode), .rs(dec_rs), .rt(dec_rt), .rd(dec_rd),
        .imm(dec_imm), .alu_op(dec_alu_op), .alu_src_imm(dec_alu_src_imm),
        .use_zero_a(dec_use_zero_a), .mem_read(dec_mem_read), .mem_write(dec_mem_write),
        .reg_write(dec_reg_write), .mem_to_reg(dec_mem_to_reg), .is_wwd(dec_is_wwd),
        .is_halt(dec_is_halt)
    );

    register_file i_register_file (
        .clk(clk), .reset_n(reset_n), .rs_addr(dec_rs), .rt_addr(dec_rt),
        .wb_write(wb_write), .wb_addr(wb_addr), .wb_data(wb_data),
        .rs_data(dec_rs_data), .rt_data(dec_rt_data)
    );

    id_ex_reg i_id_ex_reg (
        .clk(clk), .reset_n(reset_n), .stall(stall), .flush(flush),
        .instr_valid(instr_valid), .opcode_in(dec_opcode), .rt_in(dec_rt), .rd_in(dec_rd),
        .imm_in(dec_imm), .alu_op_in(dec_alu_op), .alu_src_imm_in(dec_alu_src_imm),
        .use_zero_a_in(dec_use_zero_a), .mem_read_in(dec_mem_read),
        .mem_write_in(dec_mem_write), .reg_write_in(dec_reg_write),
        .mem_to_reg_in(dec_mem_to_reg), .is_wwd_in(dec_is_wwd), .is_halt_in(dec_is_halt),
        .rs_data_in(dec_rs_data), .rt_data_in(dec_rt_data),
        .valid_out(pipe_valid), .opcode_out(pipe_opcode), .rt_out(pipe_rt), .rd_out(pipe_rd),
        .imm_out(pipe_imm), .alu_op_out(pipe_alu_op), .alu_src_imm_out(pipe_alu_src_imm),
        .use_zero_a_out(pipe_use_zero_a), .mem_read_out(pipe_mem_read),
        .mem_write_out(pipe_mem_write), .reg_write_out(pipe_reg_write),
        .mem_to_reg_out(pipe_mem_to_reg), .is_wwd_out(pipe_is_wwd),
        .is_halt_out(pipe_is_halt), .rs_data_out(pipe_rs_data), .rt_data_out(pipe_rt_data)
    );

    execute_unit i_execute_unit (
        .valid(pipe_valid), .alu_op(pipe_alu_op), .alu_src_imm(pipe_alu_src_imm),
        .use_zero_a(pipe_use_zero_a), .opcode(pipe_opcode), .rt(pipe_rt), .rd(pipe_rd),
        .rs_data(pipe_rs_data), .rt_data(pipe_rt_data), .imm(pipe_imm),
        .mem_read_in(pipe_mem_read), .mem_write_in(pipe_mem_write),
        .reg_write_in(pipe_reg_write), .mem_to_reg_in(pipe_mem_to_reg),
        .is_wwd(pipe_is_wwd), .is_halt(pipe_is_halt),
        .ex_valid(ex_valid), .alu_result(alu_result), .store_data(store_data),
        .dest_reg(dest_reg), .mem_read(mem_read), .mem_write(mem_write),
        .reg_write(reg_write), .mem_to_reg(mem_to_reg), .wwd_valid(wwd_valid),
        .wwd_value(wwd_value), .halted(halted)
    );

endmodule

`default_nettype wire

//--- sim/decode_execute_ref.svh
`ifndef DECODE_EXECUTE_REF_SVH
`define DECODE_EXECUTE_REF_SVH

// Expected execute stage outputs for one cycle.
typedef struct packed {
    logic        ex_valid;
    logic        result_known;  // Clear when the ALU result is not defined for the code.
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        mem_to_reg;
    logic        wwd_valid;
    logic        halted;
    logic [15:0] alu_result;
    logic [15:0] store_data;
    logic [15:0] wwd_value;
    logic [1:0]  dest_reg;
} expect_t;

// A bubble has every control low and no valid data.
function automatic expect_t bubble_outputs();
    expect_t e;
    e = '0;
    return e;
endfunction

function automatic expect_t predict_execute(input logic [15:0] ins,
                                            input logic [15:0] rs_val,
                                            input logic [15:0] rt_val);
    expect_t     e;
    logic [7:0]  imm8;
    logic [15:0] simm;
    e = '0;
    imm8 = ins[7:0];
    simm = {{8{imm8[7]}}, imm8};
    e.ex_valid = 1'b1;
    e.result_known = 1'b1;
    e.store_data = rt_val;
    e.wwd_value = rs_val;
    e.dest_reg = (ins[15:12] == tsc_pkg::op_rtype) ? ins[7:6] : ins[9:8];
    case (ins[15:12])
        tsc_pkg::op_adi: begin
            e.alu_result = rs_val + simm;
            e.reg_write = 1'b1;
        end
        tsc_pkg::op_ori: begin
            e.alu_result = rs_val | {8'h00, imm8};
            e.reg_write = 1'b1;
        end
        tsc_pkg::op_lhi: begin
            e.alu_result = {imm8, 8'h00};
            e.reg_write = 1'b1;
        end
        tsc_pkg::op_lwd: begin
            e.alu_result = rs_val + simm; // Address of the load.
            e.reg_write = 1'b1;
            e.mem_read = 1'b1;
            e.mem_to_reg = 1'b1;
        end
        tsc_pkg::op_swd: begin
            e.alu_result = rs_val + simm;
            e.mem_write = 1'b1;
        end
        tsc_pkg::op_rtype: begin
            e.reg_write = 1'b1;
            case (ins[5:0])
                tsc_pkg::func_add: e.alu_result = rs_val + rt_val;
                tsc_pkg::func_sub: e.alu_result = rs_val - rt_val;
                tsc_pkg::func_and: e.alu_result = rs_val & rt_val;
                tsc_pkg::func_orr: e.alu_result = rs_val | rt_val;
                tsc_pkg::func_not: e.alu_result = ~rs_val;
                tsc_pkg::func_tcp: e.alu_result = 16'd0 - rs_val;
                tsc_pkg::func_shl: e.alu_result = {rs_val[14:0], 1'b0};
                tsc_pkg::func_shr: e.alu_result = {1'b0, rs_val[15:1]};
                tsc_pkg::func_wwd: begin
                    e.reg_write = 1'b0;
                    e.wwd_valid = 1'b1;
                    e.result_known = 1'b0;
                end
                tsc_pkg::func_hlt: begin
                    e.reg_write = 1'b0;
                    e.halted = 1'b1;
                    e.result_known = 1'b0;
                end
                default: begin
                    e.reg_write = 1'b0;
                    e.result_known = 1'b0;
                end
            endcase
        end
        default: e.result_known = 1'b0;
    endcase
    return e;
endfunction

`endif

//--- sim/tb_decode_execute.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_execute;

    `include "decode_execute_ref.svh"

    localparam int  reset_cycles    = 8;
    localparam int  num_alu         = 40;
    localparam int  alu_reload      = 10;
    localparam int  num_imm         = 30;
    localparam int  num_bypass      = 8;
    localparam int  directed_cycles = 20;
    localparam int  drain_cycles    = 2;
    localparam int  total_instr     = reset_cycles + num_alu + 4 * (num_alu / alu_reload) +
                                      num_imm + 4 + num_bypass + directed_cycles +
                                      6 * drain_cycles;
    localparam real clk_period      = 40.0;

    logic        clk;
    logic        reset_n;
    logic [15:0] instr;
    logic        instr_valid;
    logic        stall;
    logic        flush;
    logic        wb_write;
    logic [1:0]  wb_addr;
    logic [15:0] wb_data;
    logic        ex_valid;
    logic [15:0] alu_result;
    logic [15:0] store_data;
    logic [1:0]  dest_reg;
    logic        mem_read;
    logic        mem_write;
    logic        reg_write;
    logic        mem_to_reg;
    logic        wwd_valid;
    logic [15:0] wwd_value;
    logic        halted;

    logic [15:0] shadow [4];    // Register contents as the write-back stimulus left them.
    expect_t     expected_q[$];
    expect_t     expected_now;
    logic        check_armed;
    int          checks;
    int          errors;
    int          error_mark;

    decode_execute_top i_decode_execute_top (
        .clk(clk), .reset_n(reset_n), .instr(instr), .instr_valid(instr_valid),
        .stall(stall), .flush(flush), .wb_write(wb_write), .wb_addr(wb_addr),
        .wb_data(wb_data), .ex_valid(ex_valid), .alu_result(alu_result),
        .store_data(store_data), .dest_reg(dest_reg), .mem_read(mem_read),
        .mem_write(mem_write), .reg_write(reg_write), .mem_to_reg(mem_to_reg),
        .wwd_valid(wwd_valid), .wwd_value(wwd_value), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2.0) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("ex_valid", 16'(ex_valid), 16'(e.ex_valid));
        check_value("reg_write", 16'(reg_write), 16'(e.reg_write));
        check_value("mem_read", 16'(mem_read), 16'(e.mem_read));
        check_value("mem_write", 16'(mem_write), 16'(e.mem_write));
        check_value("mem_to_reg", 16'(mem_to_reg), 16'(e.mem_to_reg));
        check_value("wwd_valid", 16'(wwd_valid), 16'(e.wwd_valid));
        check_value("halted", 16'(halted), 16'(e.halted));
        if (e.ex_valid) begin
            check_value("store_data", store_data, e.store_data);
            check_value("wwd_value", wwd_value, e.wwd_value);
            check_value("dest_reg", 16'(dest_reg), 16'(e.dest_reg));
            if (e.result_known) check_value("alu_result", alu_result, e.alu_result);
        end
    endtask

    // Work out what the ID/EX register holds after each edge; inputs are read before they change.
    always @(posedge clk) begin
        if (reset_n || flush) begin
            expected_now = bubble_outputs();
        end else if (!stall) begin
            if (!instr_valid) begin
                expected_now = bubble_outputs();
            end else if (expected_q.size() == 0) begin
                errors++;
                $display("Scoreboard error at %0t: instruction accepted with nothing predicted",
                         $time);
            end else begin
                expected_now = expected_q.pop_front();
            end
        end
        check_armed = 1'b1;
    end

    always @(negedge clk) begin
        if (check_armed) compare_outputs(expected_now);
    end

    task automatic drive_cycle(input logic [15:0] ins, input logic ins_valid,
                               input logic stall_in, input logic flush_in,
                               input logic wb_en, input logic [1:0] wb_a,
                               input logic [15:0] wb_d);
        expect_t e;
        @(posedge clk);
        instr       <= ins;
        instr_valid <= ins_valid;
        stall       <= stall_in;
        flush       <= flush_in;
        wb_write    <= wb_en;
        wb_addr     <= wb_a;
        wb_data     <= wb_d;
        if (wb_en) shadow[wb_a] = wb_d;   // Also covers the same-cycle bypass.
        if (ins_valid && !stall_in && !flush_in) begin
            e = predict_execute(ins, shadow[ins[11:10]], shadow[ins[9:8]]);
            expected_q.push_back(e);
        end
    endtask

    task automatic issue(input logic [15:0] ins);
        drive_cycle(ins, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 16'd0);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(16'd0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 16'd0);
    endtask

    task automatic load_registers();
        logic [15:0] ignored [4];
        // Each write cycle carries an instruction without valid that must leave a bubble.
        ignored = '{{tsc_pkg::op_lwd, 12'h000}, {tsc_pkg::op_swd, 12'h000},
                    {tsc_pkg::op_rtype, 6'd0, tsc_pkg::func_wwd},
                    {tsc_pkg::op_rtype, 6'd0, tsc_pkg::func_hlt}};
        for (int i = 0; i < 4; i++) begin
            drive_cycle(ignored[i], 1'b0, 1'b0, 1'b0, 1'b1, 2'(i), 16'($urandom()));
        end
    endtask

    task automatic finish_test(input string name);
        idle(drain_cycles);
        $display("Test %s finished with %0d errors", name, errors - error_mark);
        error_mark = errors;
    endtask

    initial begin
        #(total_instr * clk_period * 4.0);
        $display("Timeout: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [15:0] ins;
        logic [3:0]  imm_ops [5];
        logic [1:0]  a;
        void'($urandom(32'h3521_7aba));
        imm_ops = '{tsc_pkg::op_adi, tsc_pkg::op_ori, tsc_pkg::op_lhi,
                    tsc_pkg::op_lwd, tsc_pkg::op_swd};
        reset_n = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wb_write = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        check_armed = 1'b0;
        checks = 0;
        errors = 0;
        error_mark = 0;
        for (int i = 0; i < 4; i++) shadow[i] = '0;
        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b0;
        finish_test("reset");

        for (int k = 0; k < num_alu; k++) begin
            if (k % alu_reload == 0) load_registers();
            ins = {4'hf, 2'($urandom()), 2'($urandom()), 2'($urandom()),
                   6'($urandom_range(0, 7))};
            issue(ins);
        end
        finish_test("alu_ops");

        load_registers();
        for (int k = 0; k < num_imm; k++) begin
            ins = {imm_ops[$urandom_range(0, 4)], 2'($urandom()), 2'($urandom()),
                   8'($urandom())};
            issue(ins);
        end
        finish_test("immediates");

        // Stalled cycles present a different instruction that must be ignored.
        issue({tsc_pkg::op_rtype, 2'd1, 2'd2, 2'd3, tsc_pkg::func_add});
        repeat (3) drive_cycle({tsc_pkg::op_adi, 2'd0, 2'd1, 8'h7f}, 1'b1, 1'b1, 1'b0,
                               1'b0, 2'd0, 16'd0);
        issue({tsc_pkg::op_adi, 2'd0, 2'd1, 8'h7f});
        drive_cycle({tsc_pkg::op_lwd, 2'd2, 2'd3, 8'h10}, 1'b1, 1'b0, 1'b1, 1'b0, 2'd0, 16'd0);
        issue({tsc_pkg::op_lwd, 2'd2, 2'd3, 8'h10});
        // Flush and stall together after a valid instruction.
        drive_cycle({tsc_pkg::op_swd, 2'd3, 2'd0, 8'h80}, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0, 16'd0);
        drive_cycle({tsc_pkg::op_swd, 2'd3, 2'd0, 8'h80}, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 16'd0);
        issue({tsc_pkg::op_swd, 2'd3, 2'd0, 8'h80});
        finish_test("stall_flush");

        issue({tsc_pkg::op_rtype, 2'd2, 2'd0, 2'd0, tsc_pkg::func_wwd});
        issue({tsc_pkg::op_rtype, 2'd0, 2'd0, 2'd0, tsc_pkg::func_hlt});
        issue({tsc_pkg::op_rtype, 2'd1, 2'd2, 2'd3, 6'd40});   // No such function.
        issue({4'd2, 2'd1, 2'd2, 8'h33});
        issue({4'd9, 2'd3, 2'd1, 8'hc4});
        finish_test("wwd_halt_unknown");

        for (int k = 0; k < num_bypass; k++) begin
            a = 2'($urandom());
            ins = {tsc_pkg::op_rtype, 2'($urandom()), 2'($urandom()), 2'd0, tsc_pkg::func_sub};
            if (k % 2 == 0) ins[11:10] = a;
            else ins[9:8] = a;
            drive_cycle(ins, 1'b1, 1'b0, 1'b0, 1'b1, a, 16'($urandom()));
        end
        finish_test("bypass");

        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d predicted instructions never reached the outputs", expected_q.size());
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decode_execute.f
+incdir+sim
hdl/tsc_pkg.sv
hdl/register_file.sv
hdl/control_decoder.sv
hdl/id_ex_reg.sv
hdl/execute_unit.sv
hdl/decode_execute_top.sv
sim/tb_decode_execute.sv

//--- Bender.yml
package:
  name: decode_execute

sources:
  - hdl/tsc_pkg.sv
  - hdl/register_file.sv
  - hdl/control_decoder.sv
  - hdl/id_ex_reg.sv
  - hdl/execute_unit.sv
  - hdl/decode_execute_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_decode_execute.sv
